// ==== c64_cart_pkg.sv ====
// shared types and constants for the cartridge mapper, imported by every block and the testbench
`default_nettype none

package c64_cart_pkg;

	// ****************************************
	// bus and sdram widths
	// ****************************************

	typedef logic [15:0] cpu_addr_t;              // c64 cpu address
	typedef logic [7:0]  cpu_data_t;              // cpu data byte
	typedef logic [24:0] sdram_addr_t;            // sdram word address
	typedef logic [5:0]  bank_t;                  // cart bank, 64 banks max
	typedef logic [2:0]  ef_ctrl_t;               // easyflash control, only 3 bits kept

	// ****************************************
	// cartridge types
	// ****************************************

	// values follow the crt header hardware type field
	typedef enum logic [15:0]
	{
		cart_generic    = 16'd0,                  // plain 8k, 16k or ultimax
		cart_ocean      = 16'd5,                  // ocean type 1
		cart_magic_desk = 16'd19,                 // magic desk, domark, hes australia
		cart_easyflash  = 16'd32                  // easyflash, rom banking only
	} cart_type_e;

	// ****************************************
	// image layout
	// ****************************************

	// first chip packet data once the crt file header and chip header are skipped
	localparam sdram_addr_t crt_base_default = 25'h100050;

	localparam sdram_addr_t chip_8k     = 25'h2000;   // one 8k rom chip
	localparam sdram_addr_t chip_stride = 25'h2010;   // 8k data plus 16 byte chip header

	// ****************************************
	// register and window addresses
	// ****************************************

	localparam cpu_addr_t io1_bank_addr = 16'hDE00;   // bank select register
	localparam cpu_addr_t io1_ctrl_addr = 16'hDE02;   // easyflash control register

	// every rom window spans chip_8k bytes
	localparam cpu_addr_t roml_start      = 16'h8000;
	localparam cpu_addr_t romh_start      = 16'hA000;
	localparam cpu_addr_t umax_romh_start = 16'hE000; // romh moves up in ultimax

endpackage

`default_nettype wire

// ==== cart_bank_regs.sv ====
// cpu-writable cartridge registers: bank select, rom disable and easyflash control
`default_nettype none

module cart_bank_regs
	import c64_cart_pkg::*;
(
	input  wire logic       clk32,                // 32 MHz system clock
	input  wire logic       reset,                // sync, active low
	input  wire cart_type_e cart_type,            // type of the attached image
	input  wire cpu_addr_t  addr,                 // cpu address
	input  wire cpu_data_t  data,                 // cpu write data
	input  wire logic       mem_write,            // cpu write strobe
	input  wire logic       io1,                  // $de00-$deff page select
	output bank_t           bank,                 // selected rom bank
	output logic            rom_disable,          // magic desk rom off flag
	output ef_ctrl_t        ef_ctrl               // easyflash mode bits
);

	logic bank_wr;                                // write to $de00
	logic ctrl_wr;                                // write to $de02

	assign bank_wr = mem_write && (addr == io1_bank_addr);
	assign ctrl_wr = mem_write && (addr == io1_ctrl_addr);

	// ****************************************
	// per-type write decode
	// ****************************************

	always_ff @(posedge clk32)
	begin
		if (!reset)
		begin
			bank        <= '0;                    // every image boots from bank 0
			rom_disable <= 1'b0;
			ef_ctrl     <= '0;
		end
		else
		begin
			case (cart_type)
				cart_ocean:
				begin
					// any write in the io1 page, bit 7 is always set by the software
					if (mem_write && io1)
						bank <= data[5:0];
				end
				cart_magic_desk:
				begin
					if (bank_wr)
					begin
						bank        <= {2'b00, data[3:0]};    // 16 banks at most
						rom_disable <= data[7];               // exposes ram under $8000
					end
				end
				cart_easyflash:
				begin
					if (bank_wr)
						bank <= data[5:0];
					if (ctrl_wr)
						ef_ctrl <= data[2:0];         // mode bits, led bit dropped
				end
				default:
				begin
					// generic and unknown images have no registers
				end
			endcase
		end
	end

	// ****************************************
	// checks
	// ****************************************

	// the easyflash control register only moves while an easyflash image is attached
	ef_ctrl_hold: assert property (@(posedge clk32) disable iff (!reset)
		(cart_type != cart_easyflash) |=> $stable(ef_ctrl))
		else $error("ef_ctrl changed outside easyflash");

endmodule

`default_nettype wire

// ==== cart_mode_decode.sv ====
// banking mode decode: game/exrom lines, rom mapping enable and roml/romh offsets per type
`default_nettype none

module cart_mode_decode
	import c64_cart_pkg::*;
(
	input  wire cart_type_e  cart_type,           // type of the attached image
	input  wire logic        cart_attached,       // image loaded
	input  wire logic        crt_game,            // game flag from crt header
	input  wire logic        crt_exrom,           // exrom flag from crt header
	input  wire logic [15:0] cart_bank_size,      // chip packet data length
	input  wire bank_t       bank,                // selected bank
	input  wire logic        rom_disable,         // magic desk rom off
	input  wire ef_ctrl_t    ef_ctrl,             // easyflash mode
	output logic             game,                // game line to the pla
	output logic             exrom,               // exrom line to the pla
	output logic             rom_map_en,          // roml/romh reads go to the image
	output sdram_addr_t      lo_offset,           // roml bank offset into the image
	output sdram_addr_t      hi_offset            // romh bank offset into the image
);

	// stride = 8k data + 16 byte header, so bank * stride = (bank << 13) + (bank << 4)
	localparam int chip_shift = $clog2(chip_8k);
	localparam int hdr_shift  = $clog2(chip_stride - chip_8k);

	sdram_addr_t bank_off;                        // bank * chip_stride
	logic        line_game;                       // lines before the attach override
	logic        line_exrom;
	logic        map;                             // type allows mapping
	logic        known;                           // cart_type is one we handle
	logic        big_chip;                        // single 16k chip packet

	assign bank_off = (sdram_addr_t'(bank) << chip_shift) + (sdram_addr_t'(bank) << hdr_shift);
	assign big_chip = sdram_addr_t'(cart_bank_size) > chip_8k;

	// ****************************************
	// mode decode
	// ****************************************

	always_comb
	begin
		line_game  = 1'b1;                        // default is no cartridge visible
		line_exrom = 1'b1;
		map        = 1'b0;
		lo_offset  = '0;
		hi_offset  = '0;
		known      = 1'b1;
		case (cart_type)
			cart_generic:
			begin
				line_game  = crt_game;
				line_exrom = crt_exrom;
				map        = 1'b1;
				hi_offset  = big_chip ? chip_8k : chip_stride;  // skip 2nd chip header
				if (!crt_game && crt_exrom)
					hi_offset = '0;               // ultimax image holds romh first
			end
			cart_ocean:
			begin
				line_game  = 1'b0;                // 16k, same bank mirrored in both
				line_exrom = 1'b0;
				map        = 1'b1;
				lo_offset  = bank_off;
				hi_offset  = bank_off;
			end
			cart_magic_desk:
			begin
				if (!rom_disable)
				begin
					line_game  = crt_game;
					line_exrom = crt_exrom;
					map        = 1'b1;
				end
				lo_offset = bank_off;             // roml only
			end
			cart_easyflash:
			begin
				case (ef_ctrl)
					3'b100:
					begin
						// rom off, lines stay high
					end
					3'b101, 3'b110, 3'b111:
					begin
						line_game  = !ef_ctrl[0];   // 101 umax, 110 8k, 111 16k
						line_exrom = !ef_ctrl[1];
						map        = 1'b1;
						lo_offset  = bank_off;
						hi_offset  = bank_off + chip_stride;        // romh chip follows roml
					end
					default:
					begin
						line_game  = 1'b0;        // boot in ultimax from bank 0
						line_exrom = 1'b1;
						map        = 1'b1;
						hi_offset  = chip_stride;
					end
				endcase
			end
			default:
				known = 1'b0;
		endcase

		game       = cart_attached ? line_game : 1'b1;
		exrom      = cart_attached ? line_exrom : 1'b1;
		rom_map_en = cart_attached && map;

		// ultimax with a known type always needs romh, the cpu has no kernal then
		if (known && !game && exrom)
			assert (rom_map_en) else $error("ultimax lines without rom mapping");
	end

endmodule

`default_nettype wire

// ==== cart_addr_map.sv ====
// rom window decode and registered translation of cpu reads into sdram image addresses
`default_nettype none

module cart_addr_map
	import c64_cart_pkg::*;
#(
	parameter sdram_addr_t CRT_BASE = crt_base_default   // first chip data in sdram
)
(
	input  wire logic        clk32,               // 32 MHz system clock
	input  wire logic        reset,               // sync, active low
	input  wire cpu_addr_t   addr,                // cpu address
	input  wire logic        mem_write,           // cpu write strobe
	input  wire logic        roml,                // roml chip select
	input  wire logic        romh,                // romh chip select
	input  wire logic        game,                // current game line
	input  wire logic        exrom,               // current exrom line
	input  wire logic        rom_map_en,          // mapping allowed
	input  wire sdram_addr_t lo_offset,           // roml bank offset
	input  wire sdram_addr_t hi_offset,           // romh bank offset
	output sdram_addr_t      sdram_addr           // translated address, one cycle later
);

	localparam int win_bits = $clog2(chip_8k);    // windows are 8k aligned

	logic        umax;                            // game low, exrom high
	logic        mode_8k;                         // game high, exrom low, no romh
	logic        umax_win;                        // addr in $e000-$ffff while ultimax
	logic        roml_hit;
	logic        romh_hit;
	cpu_addr_t   romh_base;                       // $a000 or $e000
	sdram_addr_t next_addr;

	assign umax     = !game && exrom;
	assign mode_8k  = game && !exrom;
	assign umax_win = umax && (addr[15:win_bits] == umax_romh_start[15:win_bits]);

	// ****************************************
	// window select
	// ****************************************

	assign roml_hit = rom_map_en && !mem_write && roml
		&& (addr[15:win_bits] == roml_start[15:win_bits]);

	assign romh_hit = rom_map_en && !mem_write && romh && !mode_8k
		&& ((addr[15:win_bits] == romh_start[15:win_bits]) || umax_win);

	assign romh_base = umax_win ? umax_romh_start : romh_start;

	always_comb
	begin
		next_addr = sdram_addr_t'(addr);          // pass through by default
		if (roml_hit)
			next_addr = CRT_BASE + lo_offset + sdram_addr_t'(addr - roml_start);
		else if (romh_hit)
			next_addr = CRT_BASE + hi_offset + sdram_addr_t'(addr - romh_base);
	end

	// ****************************************
	// output register
	// ****************************************

	always_ff @(posedge clk32)
	begin
		if (!reset)
			sdram_addr <= '0;
		else
			sdram_addr <= next_addr;              // one access per cycle, no stall
	end

	// a mapped read lands inside the image on the next cycle
	map_in_image: assert property (@(posedge clk32) disable iff (!reset)
		(roml_hit || romh_hit) |=> (sdram_addr >= CRT_BASE))
		else $error("mapped address below CRT_BASE");

endmodule

`default_nettype wire

// ==== cartridge.sv ====
// expansion port cartridge top level: bank registers, mode decode and sdram address map
`default_nettype none

module cartridge
	import c64_cart_pkg::*;
#(
	parameter sdram_addr_t CRT_BASE = crt_base_default   // image load address in sdram
)
(
	input  wire logic        clk32,               // 32 MHz system clock
	input  wire logic        reset,               // sync, active low
	input  wire cpu_addr_t   addr,                // cpu address
	input  wire cpu_data_t   data,                // cpu write data
	input  wire logic        mem_write,           // cpu write strobe
	input  wire logic        io1,                 // $de00 page
	input  wire logic        roml,                // roml chip select
	input  wire logic        romh,                // romh chip select
	input  wire logic [15:0] cart_id,             // crt hardware type
	input  wire logic [15:0] cart_bank_size,      // chip packet data length
	input  wire logic        crt_game,            // crt header game flag
	input  wire logic        crt_exrom,           // crt header exrom flag
	input  wire logic        cart_attached,       // image loaded
	output sdram_addr_t      sdram_addr,          // translated read address
	output logic             game,                // game line
	output logic             exrom                // exrom line
);

	cart_type_e  cart_type;
	bank_t       bank;
	logic        rom_disable;
	ef_ctrl_t    ef_ctrl;
	logic        rom_map_en;
	sdram_addr_t lo_offset;
	sdram_addr_t hi_offset;

	assign cart_type = cart_type_e'(cart_id);     // unlisted ids fall to the unknown case

	cart_bank_regs cart_bank_regs_i
	(
		.clk32, .reset, .cart_type, .addr, .data, .mem_write, .io1,
		.bank, .rom_disable, .ef_ctrl
	);

	cart_mode_decode cart_mode_decode_i
	(
		.cart_type, .cart_attached, .crt_game, .crt_exrom, .cart_bank_size,
		.bank, .rom_disable, .ef_ctrl,
		.game, .exrom, .rom_map_en, .lo_offset, .hi_offset
	);

	cart_addr_map #(.CRT_BASE(CRT_BASE)) cart_addr_map_i
	(
		.clk32, .reset, .addr, .mem_write, .roml, .romh,
		.game, .exrom, .rom_map_en, .lo_offset, .hi_offset,
		.sdram_addr
	);

endmodule

`default_nettype wire

// ==== cartridge_tb.sv ====
// self-checking testbench for the cartridge mapper, random cpu bus traffic against a model
`default_nettype none

module cartridge_tb
	import c64_cart_pkg::*;
();

	localparam int phase_cycles = 300;                    // bus cycles per test phase
	localparam int max_cycles   = 6 * phase_cycles + 100; // all phases plus reset slack
	localparam logic [15:0] known_ids [4] = '{16'd0, 16'd5, 16'd19, 16'd32};

	logic        clk32 = 1'b0;
	logic        reset, mem_write, io1, roml, romh;
	logic        crt_game, crt_exrom, cart_attached;
	cpu_addr_t   addr;
	cpu_data_t   data;
	logic [15:0] cart_id, cart_bank_size;
	sdram_addr_t sdram_addr;
	logic        game, exrom;

	bank_t       m_bank;                                  // model registers
	logic        m_rom_dis;
	ef_ctrl_t    m_ef;
	logic        m_game, m_exrom, m_map;                  // model lines and mapping enable
	sdram_addr_t m_lo, m_hi;
	sdram_addr_t exp_addr;                                // expected sdram_addr after this edge
	string       test_name;
	int          cycles = 0;
	int unsigned seed;

	cartridge cartridge_i (.*);                           // default CRT_BASE

	always
		#5 clk32 = ~clk32;

	// run limit
	always @(posedge clk32)
	begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("timeout, run did not finish within %0d cycles", max_cycles);
			$display("Errors found");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic report_error(input sdram_addr_t expected, input sdram_addr_t actual,
		input string what);
		$display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
		$display("Errors found");
		$fatal(1, "stopped at first mismatch");
	endtask

	// ****************************************
	// reference model
	// ****************************************

	// lines, mapping enable and offsets per cartridge type from the model registers
	task automatic decode_mode();
		sdram_addr_t off;
		off  = sdram_addr_t'(m_bank) * chip_stride;       // bank x $2010
		m_lo = off;
		m_hi = '0;
		case (cart_id)
			cart_generic:
			begin
				{m_game, m_exrom, m_map} = {crt_game, crt_exrom, 1'b1};
				m_lo = '0;
				if (crt_game || !crt_exrom)               // ultimax leaves romh at 0
					m_hi = (cart_bank_size > 16'h2000) ? chip_8k : chip_stride;
			end
			cart_ocean:
			begin
				{m_game, m_exrom, m_map} = 3'b001;        // 16k, one bank in both windows
				m_hi = off;
			end
			cart_magic_desk:
				{m_game, m_exrom, m_map} = m_rom_dis ? 3'b110 : {crt_game, crt_exrom, 1'b1};
			cart_easyflash:
			begin
				case (m_ef)
					3'b100:  {m_game, m_exrom, m_map} = 3'b110;   // rom off
					3'b110:  {m_game, m_exrom, m_map} = 3'b101;   // 8k
					3'b111:  {m_game, m_exrom, m_map} = 3'b001;   // 16k
					default: {m_game, m_exrom, m_map} = 3'b011;   // 101 and boot ultimax
				endcase
				if (!m_ef[2])
					m_lo = '0;                            // boot mode ignores bank
				m_hi = m_lo + chip_stride;
			end
			default:
				{m_game, m_exrom, m_map} = 3'b110;        // unknown id
		endcase
		if (!cart_attached)
			{m_game, m_exrom, m_map} = 3'b110;
	endtask

	// expected address for the access sampled at this edge, then the register writes
	task automatic model_edge();
		logic rd;
		decode_mode();
		rd       = m_map && !mem_write;
		exp_addr = sdram_addr_t'(addr);                   // unmapped accesses pass through
		if (!reset)
			exp_addr = '0;
		else if (rd && roml && addr >= 16'h8000 && addr <= 16'h9FFF)
			exp_addr = crt_base_default + m_lo + sdram_addr_t'(addr - 16'h8000);
		else if (rd && romh && addr >= 16'hA000 && addr <= 16'hBFFF && !(m_game && !m_exrom))
			exp_addr = crt_base_default + m_hi + sdram_addr_t'(addr - 16'hA000);
		else if (rd && romh && addr >= 16'hE000 && !m_game && m_exrom)
			exp_addr = crt_base_default + m_hi + sdram_addr_t'(addr - 16'hE000);
		if (!reset)
			{m_bank, m_rom_dis, m_ef} = '0;
		else if (mem_write)
		begin
			if (cart_id == cart_ocean && io1)
				m_bank = data[5:0];
			if (cart_id == cart_magic_desk && addr == 16'hDE00)
				{m_rom_dis, m_bank} = {data[7], 2'b00, data[3:0]};
			if (cart_id == cart_easyflash && addr == 16'hDE00)
				m_bank = data[5:0];
			if (cart_id == cart_easyflash && addr == 16'hDE02)
				m_ef = data[2:0];
		end
	endtask

	// ****************************************
	// stimulus
	// ****************************************

	// one random bus cycle, mostly register writes and rom window reads
	task automatic drive_bus();
		int unsigned sel;
		cpu_addr_t   a;
		sel = $urandom % 10;
		a   = cpu_addr_t'($urandom);
		if (sel < 3)
			a = (sel == 0) ? 16'hDE00 : (sel == 1) ? 16'hDE02 : {8'hDE, a[7:0]};
		else if (sel < 8)
			a[15:13] = (sel < 5) ? 3'b100 : (sel < 7) ? 3'b101 : 3'b111;
		addr      <= a;
		data      <= cpu_data_t'($urandom);
		mem_write <= (sel < 3) || (sel == 9 && $urandom % 2 == 1);
		io1       <= (a[15:8] == 8'hDE);
		roml      <= (a[15:13] == 3'b100) || (sel == 9 && $urandom % 4 == 0);
		romh      <= (a[15:13] == 3'b101) || (a[15:13] == 3'b111);
	endtask

	task automatic run_phase(input int phase, input string name, input logic [15:0] id);
		int i;
		test_name = name;
		for (i = 0; i < phase_cycles; i++)
		begin
			@(posedge clk32);
			model_edge();
			if (i == 0)
				{cart_id, cart_attached, crt_game, crt_exrom, cart_bank_size} <=
					{id, phase != 0, 2'b10, 16'h2000};    // 8k flags by default
			case (phase)
				0:
				begin
					if (i < 200 && i % 25 == 0)
						cart_id <= known_ids[2'($urandom % 4)];
					if (i == 200)
					begin
						test_name = "unknown_type";
						cart_id       <= 16'd7;
						cart_attached <= 1'b1;
					end
				end
				1:
				begin
					if (i == 100)
						{crt_game, crt_exrom, cart_bank_size} <= {2'b00, 16'h4000};  // one 16k chip
					if (i == 150)
						cart_bank_size <= 16'h2000;       // 16k from two 8k chips
					if (i == 200)
						{crt_game, crt_exrom} <= 2'b01;   // ultimax
				end
				5:
				begin
					if (i == 150 || i == 153)
						reset <= (i == 153);              // 3 cycle pulse mid-run
				end
				default:
				begin
				end
			endcase
			drive_bus();
			@(negedge clk32);
			decode_mode();                                // lines follow this edge's writes
			assert (game == m_game && exrom == m_exrom)
			else
				report_error({23'd0, m_game, m_exrom}, {23'd0, game, exrom}, "game/exrom");
			assert (sdram_addr == exp_addr)
			else
				report_error(exp_addr, sdram_addr, "sdram_addr");
		end
	endtask

	initial
	begin
		seed = $urandom(17);
		{reset, mem_write, io1, roml, romh, crt_game, crt_exrom, cart_attached} = '0;
		{addr, data, cart_id, cart_bank_size} = '0;
		{m_bank, m_rom_dis, m_ef} = '0;
		repeat (10) @(posedge clk32);
		reset <= 1'b1;
		run_phase(0, "detached", 16'd0);
		run_phase(1, "generic", cart_generic);
		run_phase(2, "ocean", cart_ocean);
		run_phase(3, "magic_desk", cart_magic_desk);
		run_phase(4, "easyflash", cart_easyflash);
		run_phase(5, "reset_mid_run", cart_easyflash);
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
c64_cart_pkg.sv
cart_bank_regs.sv
cart_mode_decode.sv
cart_addr_map.sv
cartridge.sv
cartridge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cartridge_tb
SEED      ?= 17
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) +verilator+seed+$(SEED)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
